/* filelist.f */
source/rack_pkg.sv
source/param_if.sv
source/param_bank.sv
source/sim_tick_gen.sv
source/synapse_current.sv
source/gain_step_ctrl.sv
source/drive_mixer.sv
source/lif_neuron.sv
source/rack_node_top.sv
tb/tb_rack_node.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rack_node
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); test $$rc -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_rack_node.sv */
`timescale 1ns/100ps

module tb_rack_node
    import rack_pkg::*;
();

    localparam int SYN_WEIGHT     = 64;
    localparam int DECAY_SHIFT    = 3;
    localparam int LEAK_SHIFT     = 4;
    // tests take roughly 150 ticks of at most 16 clocks
    localparam int TIMEOUT_CYCLES = 20000;

    logic        ep50trig;
    logic        reset_global;
    logic        i_spike_ia;
    logic        i_spike_ii;
    logic        i_button;
    logic        i_cfg_wr;
    cfg_addr_e   i_cfg_addr;
    logic [31:0] i_cfg_data;
    logic        o_sim_tick;
    logic        o_spike;
    current_t    o_drive;
    count_t      o_spike_count;
    step_t       o_gain_step;

    int errors;
    int checks;
    int cycle_count;
    int gap;
    logic [31:0] rnd;

    // reference state, one update per tick
    logic [31:0] m_ia;
    logic [31:0] m_ii;
    logic        m_s1;
    logic        m_s2;
    logic [3:0]  m_pre;
    logic [31:0] m_drive;
    logic [31:0] m_v;
    logic [31:0] m_count;
    // shadow of the loaded parameters
    logic [15:0] m_gain;
    logic [31:0] m_extra;
    logic [31:0] m_thr;

    rack_node_top #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT),
        .LEAK_SHIFT  (LEAK_SHIFT)
    ) rack_node_top_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike_ia    (i_spike_ia),
        .i_spike_ii    (i_spike_ii),
        .i_button      (i_button),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg_addr    (i_cfg_addr),
        .i_cfg_data    (i_cfg_data),
        .o_sim_tick    (o_sim_tick),
        .o_spike       (o_spike),
        .o_drive       (o_drive),
        .o_spike_count (o_spike_count),
        .o_gain_step   (o_gain_step)
    );

    // 20 ns period
    always #10 ep50trig = ~ep50trig;

    // model runs at the falling edge, ahead of the tick edge it predicts
    always @(negedge ep50trig) begin : ref_model
        logic [31:0] nv;
        logic [31:0] comp;
        logic        fire_exp;
        if (reset_global) begin
            m_ia    = '0;
            m_ii    = '0;
            m_s1    = 1'b0;
            m_s2    = 1'b0;
            m_pre   = '0;
            m_drive = '0;
            m_v     = '0;
            m_count = '0;
            m_gain  = 16'd512;
            m_extra = '0;
            m_thr   = 32'd30720;
        end else begin
            fire_exp = 1'b0;
            if (o_sim_tick) begin
                // neuron uses the drive held before this tick
                nv = m_v - (m_v >> LEAK_SHIFT) + m_drive;
                // spike strobe is high for the whole tick cycle
                fire_exp = (nv >= m_thr);
                if (fire_exp) begin
                    m_v     = '0;
                    m_count = m_count + 32'd1;
                end else begin
                    m_v = nv;
                end
                // q8.8 gain, drop the fraction, then compensation shift
                comp    = (((m_ia + m_ii) * {16'd0, m_gain}) >> 8) << 9;
                m_drive = comp + comp * {29'd0, m_pre[3:1]} + m_extra;
                // level change seen between the two button stages
                if (m_s1 != m_s2) begin
                    m_pre = (m_pre == 4'd14) ? 4'd0 : m_pre + 4'd1;
                end
                m_s2 = m_s1;
                m_s1 = i_button;
                m_ia = m_ia - (m_ia >> DECAY_SHIFT) + (i_spike_ia ? SYN_WEIGHT : 0);
                m_ii = m_ii - (m_ii >> DECAY_SHIFT) + (i_spike_ii ? SYN_WEIGHT : 0);
            end
            // no spike outside a tick cycle
            check_value("spike", 32'(o_spike), 32'(fire_exp));
            // a write lands after any tick at the same edge
            if (i_cfg_wr) begin
                case (i_cfg_addr)
                    CFG_GAIN:      m_gain  = i_cfg_data[15:0];
                    CFG_EXTRA:     m_extra = i_cfg_data;
                    CFG_THRESHOLD: m_thr   = i_cfg_data;
                    default:       m_gain  = m_gain;
                endcase
            end
        end
    end

    // run limit
    always @(posedge ep50trig) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d of %0d checks", errors, checks);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // returns just after the tick edge, cycles counted since the call
    task automatic wait_tick(output int cycles);
        cycles = 0;
        do begin
            @(negedge ep50trig);
            cycles++;
        end while (!o_sim_tick);
        @(posedge ep50trig);
        #2;
    endtask

    task automatic cfg_write(input cfg_addr_e addr, input logic [31:0] data);
        i_cfg_wr   = 1'b1;
        i_cfg_addr = addr;
        i_cfg_data = data;
        @(posedge ep50trig);
        #2;
        i_cfg_wr   = 1'b0;
    endtask

    task automatic reset_values();
        check_value("sim tick", 32'(o_sim_tick), 0);
        check_value("spike", 32'(o_spike), 0);
        check_value("drive", o_drive, 0);
        check_value("spike count", o_spike_count, 0);
        check_value("gain step", 32'(o_gain_step), 0);
        // first tick is a full period after release
        wait_tick(gap);
        check_value("first tick delay", gap, 10);
        wait_tick(gap);
        check_value("tick spacing", gap, 10);
        check_value("drive", o_drive, m_drive);
    endtask

    task automatic tick_config();
        cfg_write(CFG_HALF_CNT, 32'd8);
        // next restart picks up the new half count
        wait_tick(gap);
        wait_tick(gap);
        check_value("tick spacing", gap, 16);
        // zero half count is dropped
        cfg_write(CFG_HALF_CNT, 32'd0);
        wait_tick(gap);
        wait_tick(gap);
        check_value("tick spacing", gap, 16);
    endtask

    task automatic extra_drive_neuron();
        cfg_write(CFG_THRESHOLD, 32'd5000);
        cfg_write(CFG_EXTRA, 32'd1000);
        wait_tick(gap);
        check_value("drive", o_drive, 32'd1000);
        repeat (30) begin
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
            check_value("spike count", o_spike_count, m_count);
        end
    endtask

    task automatic synapse_gain();
        // gain 1.5
        cfg_write(CFG_GAIN, 32'h0180);
        i_spike_ia = 1'b1;
        repeat (5) begin
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
        end
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b1;
        repeat (5) begin
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
        end
        i_spike_ii = 1'b0;
        repeat (3) begin
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
        end
        check_value("spike count", o_spike_count, m_count);
    endtask

    task automatic button_step();
        for (int n = 1; n <= 17; n++) begin
            i_button = ~i_button;
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
            // two edges per step, wraps after 15 edges
            check_value("gain step", 32'(o_gain_step), 32'((n % 15) / 2));
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
        end
    endtask

    task automatic random_spikes();
        repeat (40) begin
            rnd        = $urandom();
            i_spike_ia = rnd[0];
            i_spike_ii = rnd[1];
            wait_tick(gap);
            check_value("drive", o_drive, m_drive);
        end
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
        check_value("spike count", o_spike_count, m_count);
    endtask

    initial begin
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_spike_ia   = 1'b0;
        i_spike_ii   = 1'b0;
        i_button     = 1'b0;
        i_cfg_wr     = 1'b0;
        i_cfg_addr   = CFG_GAIN;
        i_cfg_data   = '0;
        errors       = 0;
        checks       = 0;
        cycle_count  = 0;
        rnd          = $urandom(32'h5dc38e52);
        repeat (8) @(posedge ep50trig);
        #2;
        reset_global = 1'b0;
        reset_values();
        tick_config();
        extra_drive_neuron();
        synapse_gain();
        button_step();
        random_spikes();
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* source/rack_node_top.sv */
`timescale 1ns/100ps

module rack_node_top
    import rack_pkg::*;
#(
    parameter int unsigned SYN_WEIGHT  = 64,
    parameter int unsigned DECAY_SHIFT = 3,
    parameter int unsigned LEAK_SHIFT  = 4
) (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_spike_ia,
    input  logic        i_spike_ii,
    input  logic        i_button,
    input  logic        i_cfg_wr,
    input  cfg_addr_e   i_cfg_addr,
    input  logic [31:0] i_cfg_data,
    output logic        o_sim_tick,
    output logic        o_spike,
    output current_t    o_drive,
    output count_t      o_spike_count,
    output step_t       o_gain_step
);

    // synapse outputs into the mixer
    current_t current_ia;
    current_t current_ii;

    // loaded run parameters
    param_if p_if ();

    param_bank param_bank_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .p            (p_if)
    );

    sim_tick_gen sim_tick_gen_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .p            (p_if),
        .o_tick       (o_sim_tick)
    );

    // ia input
    synapse_current #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT)
    ) syn_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_sim_tick),
        .i_spike      (i_spike_ia),
        .o_current    (current_ia)
    );

    // ii input
    synapse_current #(
        .SYN_WEIGHT  (SYN_WEIGHT),
        .DECAY_SHIFT (DECAY_SHIFT)
    ) syn_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_sim_tick),
        .i_spike      (i_spike_ii),
        .o_current    (current_ii)
    );

    gain_step_ctrl gain_step_ctrl_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_sim_tick),
        .i_button     (i_button),
        .o_step       (o_gain_step)
    );

    drive_mixer drive_mixer_inst (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick       (o_sim_tick),
        .i_current_ia (current_ia),
        .i_current_ii (current_ii),
        .i_step       (o_gain_step),
        .p            (p_if),
        .o_drive      (o_drive)
    );

    // neuron sees the drive latched on the previous tick
    lif_neuron #(
        .LEAK_SHIFT (LEAK_SHIFT)
    ) lif_neuron_inst (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_tick        (o_sim_tick),
        .i_drive       (o_drive),
        .p             (p_if),
        .o_spike       (o_spike),
        .o_spike_count (o_spike_count)
    );

endmodule

/* source/lif_neuron.sv */
`timescale 1ns/100ps

module lif_neuron
    import rack_pkg::*;
#(
    parameter int unsigned LEAK_SHIFT = 4
) (
    input  logic     ep50trig,
    input  logic     reset_global,
    input  logic     i_tick,
    input  current_t i_drive,
    param_if.user    p,
    output logic     o_spike,
    output count_t   o_spike_count
);

    // membrane potential
    current_t v_q;
    current_t leak;
    current_t v_next;
    count_t   count_q;
    logic     fire;

    // leak proportional to the membrane, then add the latched drive
    assign leak   = v_q >> LEAK_SHIFT;
    assign v_next = v_q - leak + i_drive;

    // threshold crossing only counts on the tick
    assign fire    = i_tick && (v_next >= p.threshold);
    assign o_spike = fire;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            v_q     <= '0;
            count_q <= '0;
        end else if (i_tick) begin
            if (fire) begin
                // reset membrane after a spike
                v_q     <= '0;
                count_q <= count_q + 32'd1;
            end else begin
                v_q <= v_next;
            end
        end
    end

    assign o_spike_count = count_q;

    // spike strobe aligned to the tick from sim_tick_gen
    spike_on_tick_a: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_spike |-> i_tick
    );

endmodule

/* source/drive_mixer.sv */
`timescale 1ns/100ps

module drive_mixer
    import rack_pkg::*;
(
    input  logic     ep50trig,
    input  logic     reset_global,
    input  logic     i_tick,
    input  current_t i_current_ia,
    input  current_t i_current_ii,
    input  step_t    i_step,
    param_if.user    p,
    output current_t o_drive
);

    // both synapses together
    current_t sum_cur;
    // sum times gain, still q.8
    current_t gained;
    // integer part after the gain, then neuron compensation
    current_t comp_cur;
    // button term, comp_cur times the step
    current_t step_term;
    current_t drive_next;
    current_t drive_q;

    // everything wraps at 32 bits
    assign sum_cur    = i_current_ia + i_current_ii;
    assign gained     = sum_cur * current_t'(p.gain);
    assign comp_cur   = (gained >> GAIN_FRAC_BITS) << COMP_SHIFT;
    assign step_term  = comp_cur * current_t'(i_step);
    assign drive_next = comp_cur + step_term + p.extra_drive;

    // latch once per tick
    // inputs here are the synapse values from before this tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            drive_q <= '0;
        end else if (i_tick) begin
            drive_q <= drive_next;
        end
    end

    assign o_drive = drive_q;

endmodule

/* source/gain_step_ctrl.sv */
`timescale 1ns/100ps

module gain_step_ctrl
    import rack_pkg::*;
(
    input  logic  ep50trig,
    input  logic  reset_global,
    input  logic  i_tick,
    input  logic  i_button,
    output step_t o_step
);

    // button sampled once per tick, two stages
    logic       btn_s1_q;
    logic       btn_s2_q;
    // counts level changes, 0..STEP_WRAP
    logic [3:0] pre_q;
    logic       level_change;

    assign level_change = btn_s1_q ^ btn_s2_q;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            btn_s1_q <= 1'b0;
            btn_s2_q <= 1'b0;
            pre_q    <= '0;
        end else if (i_tick) begin
            btn_s1_q <= i_button;
            btn_s2_q <= btn_s1_q;
            // change seen one tick after sampling, step two ticks after
            if (level_change) begin
                if (pre_q == 4'(STEP_WRAP)) begin
                    pre_q <= '0;
                end else begin
                    pre_q <= pre_q + 4'd1;
                end
            end
        end
    end

    // two button edges per step
    assign o_step = pre_q[3:1];

    // wrap keeps the step within 0..7
    prescaler_range_a: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        pre_q <= 4'(STEP_WRAP)
    );

endmodule

/* source/synapse_current.sv */
`timescale 1ns/100ps

module synapse_current
    import rack_pkg::*;
#(
    parameter int unsigned SYN_WEIGHT  = 64,
    parameter int unsigned DECAY_SHIFT = 3
) (
    input  logic     ep50trig,
    input  logic     reset_global,
    input  logic     i_tick,
    input  logic     i_spike,
    output current_t o_current
);

    // held current
    current_t current_q;
    // weight added this tick, zero without a spike
    current_t add_w;
    // exponential decay term
    current_t decay;
    current_t current_next;

    assign add_w        = i_spike ? current_t'(SYN_WEIGHT) : '0;
    assign decay        = current_q >> DECAY_SHIFT;
    // decay never exceeds the current, so no underflow
    assign current_next = current_q - decay + add_w;

    // spike input is sampled only on the tick
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            current_q <= '0;
        end else if (i_tick) begin
            current_q <= current_next;
        end
    end

    assign o_current = current_q;

endmodule

/* source/sim_tick_gen.sv */
`timescale 1ns/100ps

module sim_tick_gen
    import rack_pkg::*;
(
    input  logic  ep50trig,
    input  logic  reset_global,
    param_if.user p,
    output logic  o_tick
);

    // clock count within the current period
    logic [16:0] cnt_q;
    // last count of the running period, 2*half_cnt - 1
    logic [16:0] last_q;

    // tick on the final clock of each period
    assign o_tick = (cnt_q == last_q);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cnt_q  <= '0;
            last_q <= {HALF_CNT_RESET, 1'b0} - 17'd1;
        end else if (o_tick) begin
            cnt_q  <= '0;
            // pick up a new half count only at restart
            last_q <= {p.half_cnt, 1'b0} - 17'd1;
        end else begin
            cnt_q <= cnt_q + 17'd1;
        end
    end

    // period is at least two clocks so ticks never touch
    tick_single_cycle_a: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_tick |=> !o_tick
    );

endmodule

/* source/param_bank.sv */
`timescale 1ns/100ps

module param_bank
    import rack_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_cfg_wr,
    input  cfg_addr_e   i_cfg_addr,
    input  logic [31:0] i_cfg_data,
    param_if.bank       p
);

    // low half of the data word, used by the 16-bit registers
    logic [15:0] data_lo;

    assign data_lo = i_cfg_data[15:0];

    // one register per address, loaded on the write strobe
    // new value is seen by the users one cycle after the strobe
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            p.gain        <= GAIN_RESET;
            p.extra_drive <= '0;
            p.half_cnt    <= HALF_CNT_RESET;
            p.threshold   <= THRESHOLD_RESET;
        end else if (i_cfg_wr) begin
            case (i_cfg_addr)
                CFG_GAIN: begin
                    p.gain <= data_lo;
                end
                CFG_EXTRA: begin
                    p.extra_drive <= i_cfg_data;
                end
                CFG_HALF_CNT: begin
                    // zero would stall the tick counter, drop it
                    if (data_lo != '0) begin
                        p.half_cnt <= data_lo;
                    end
                end
                CFG_THRESHOLD: begin
                    p.threshold <= i_cfg_data;
                end
                default: begin
                    p.gain <= p.gain;
                end
            endcase
        end
    end

    // tick generator period depends on a nonzero half count
    // checked across reset release and every later write
    half_cnt_nonzero_a: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        p.half_cnt != '0
    );

endmodule

/* source/param_if.sv */
`timescale 1ns/100ps

interface param_if
    import rack_pkg::*;
();

    // synapse gain, q8.8
    gain_t     gain;
    // host-loaded drive added after the gain stage
    current_t  extra_drive;
    // tick half period
    half_cnt_t half_cnt;
    // neuron firing threshold
    current_t  threshold;

    // register side
    modport bank (
        output gain, extra_drive, half_cnt, threshold
    );

    // consumer side
    modport user (
        input gain, extra_drive, half_cnt, threshold
    );

endinterface

/* source/rack_pkg.sv */
package rack_pkg;

    // synaptic current and neuron drive, plain unsigned integer
    typedef logic [31:0] current_t;
    // synapse gain, unsigned q8.8
    typedef logic [15:0] gain_t;
    // running spike total
    typedef logic [31:0] count_t;
    // half of the tick period, in clocks
    typedef logic [15:0] half_cnt_t;
    // button-selected sensory gain step, 0..7
    typedef logic [2:0] step_t;

    // configuration register addresses
    typedef enum logic [1:0] {
        CFG_GAIN      = 2'd0,
        CFG_EXTRA     = 2'd1,
        CFG_HALF_CNT  = 2'd2,
        CFG_THRESHOLD = 2'd3
    } cfg_addr_e;

    // fraction bits of the gain format
    localparam int GAIN_FRAC_BITS = 8;
    // fixed scale applied after the gain, neuron compensation
    localparam int COMP_SHIFT = 9;

    // 2.0 in q8.8
    localparam gain_t GAIN_RESET = 16'd512;
    // 10 clocks per tick
    localparam half_cnt_t HALF_CNT_RESET = 16'd5;
    // 30 << 10
    localparam current_t THRESHOLD_RESET = 32'd30720;

    // last pre-scaler value before it wraps to zero
    localparam int STEP_WRAP = 14;

endpackage
